/* design/fp_convert_config.svh */
`ifndef FP_CONVERT_CONFIG_SVH
`define FP_CONVERT_CONFIG_SVH

// Width of a raw single-precision word
`define FP_FLOAT_WIDTH 32

// Width of the signed integer word on both paths
`define FP_INT_WIDTH 32

// Mantissa width with the hidden bit, so the stored fraction is one bit less
`define FP_MANT_WIDTH 24

// Exponent field width of the float encoding
`define FP_EXP_WIDTH 8

// Bias subtracted from the stored exponent field
`define FP_EXP_BIAS 127

// Clocks from an accepted input strobe to its output strobe
`define FP_PIPE_DEPTH 3

`endif

/* design/fp_convert_pkg.sv */
`include "fp_convert_config.svh"

package fp_convert_pkg;

    // Raw single-precision word, sign in the MSB
    typedef logic [`FP_FLOAT_WIDTH-1:0] float_t;

    // Two's complement integer as seen on both converter ports
    typedef logic signed [`FP_INT_WIDTH-1:0] int_t;

    // Mantissa with the hidden bit restored at the top
    typedef logic [`FP_MANT_WIDTH-1:0] mant_t;

    // Unbiased exponent
    // The stored field of 255 wraps here, so infinities and NaNs are flagged apart
    typedef logic signed [`FP_EXP_WIDTH-1:0] exp_t;

    // Position of the integer LSB inside the mantissa
    // Zero means the mantissa needs no rounding at all
    typedef logic signed [`FP_EXP_WIDTH-1:0] shift_t;

endpackage

/* design/fp_convert_unit.sv */
`timescale 1ns/1ps

module fp_convert_unit (
    input  logic                   clock,
    input  logic                   rst_n,
    // Float to integer path
    input  logic                   fti_in_valid,
    input  fp_convert_pkg::float_t fti_in_data,
    output logic                   fti_out_valid,
    output fp_convert_pkg::int_t   fti_out_data,
    // Integer to float path
    input  logic                   itf_in_valid,
    input  fp_convert_pkg::int_t   itf_in_data,
    output logic                   itf_out_valid,
    output fp_convert_pkg::float_t itf_out_data
);

    // The two paths are independent and only share clock and reset
    fp_fti fti (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (fti_in_valid),
        .in_data   (fti_in_data),
        .out_valid (fti_out_valid),
        .out_data  (fti_out_data)
    );

    fp_itf itf (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (itf_in_valid),
        .in_data   (itf_in_data),
        .out_valid (itf_out_valid),
        .out_data  (itf_out_data)
    );

endmodule

/* design/fp_fti.sv */
`timescale 1ns/1ps
`include "fp_convert_config.svh"

module fp_fti (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  fp_convert_pkg::float_t in_data,
    output logic                   out_valid,
    output fp_convert_pkg::int_t   out_data
);

    localparam int FRAC_BITS = `FP_MANT_WIDTH - 1;
    localparam int EXP_LSB   = FRAC_BITS;
    localparam int INT_MSB   = `FP_INT_WIDTH - 1;

    // Saturation limits of the signed result
    localparam fp_convert_pkg::int_t INT_MAX = {1'b0, {INT_MSB{1'b1}}};
    localparam fp_convert_pkg::int_t INT_MIN = {1'b1, {INT_MSB{1'b0}}};

    logic s1_valid;
    logic s2_valid;

    // Valid strobe travels alongside the data, one register per stage
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Stage 1 splits the float into its fields
    //////////////////////////////////////////////////////////////////////////

    logic                  s1_sign;
    fp_convert_pkg::exp_t  s1_exp;
    fp_convert_pkg::mant_t s1_mant;
    logic                  s1_subnormal;
    logic                  s1_frac_zero;
    logic                  s1_special;

    always_ff @(posedge clock) begin
        if (in_valid) begin
            s1_sign      <= in_data[`FP_FLOAT_WIDTH-1];
            // Hidden bit restored here; subnormals are flushed later anyway
            s1_mant      <= {1'b1, in_data[FRAC_BITS-1:0]};
            s1_exp       <= fp_convert_pkg::exp_t'(
                $signed({1'b0, in_data[EXP_LSB +: `FP_EXP_WIDTH]}) - `FP_EXP_BIAS);
            s1_subnormal <= (in_data[EXP_LSB +: `FP_EXP_WIDTH] == '0);
            s1_frac_zero <= (in_data[FRAC_BITS-1:0] == '0);
            // Infinity and NaN, whose unbiased exponent does not fit in exp_t
            s1_special   <= (in_data[EXP_LSB +: `FP_EXP_WIDTH] == '1);
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Stage 2 moves the binary point and saturates
    //////////////////////////////////////////////////////////////////////////

    logic                         overflow;
    logic [`FP_INT_WIDTH-1:0]     mant_wide;
    fp_convert_pkg::int_t         shifted;
    fp_convert_pkg::shift_t       lsb_index;

    // Exactly 2^31 with the sign set is the one exponent-31 value that fits
    // It takes the shift path as 0x80000000, which negates to that same value
    assign overflow = s1_special || (s1_exp > 31) ||
                      ((s1_exp == 31) && (!s1_sign || !s1_frac_zero));

    assign mant_wide = `FP_INT_WIDTH'(s1_mant);

    always_comb begin
        if (overflow) begin
            shifted = s1_sign ? INT_MIN : INT_MAX;
        end else if (s1_subnormal || (s1_exp < 0)) begin
            shifted = '0;
        end else if (s1_exp < FRAC_BITS) begin
            shifted = mant_wide >> (FRAC_BITS - s1_exp);
        end else begin
            shifted = mant_wide << (s1_exp - FRAC_BITS);
        end
    end

    // Exponent -1 gives index 24, so the hidden bit acts as guard and 0.5 ties to 0
    // From exponent 23 up every mantissa bit lands in the integer
    always_comb begin
        if ((s1_exp < -1) || (s1_exp >= FRAC_BITS)) begin
            lsb_index = '0;
        end else begin
            lsb_index = fp_convert_pkg::shift_t'(FRAC_BITS - s1_exp);
        end
    end

    logic                   s2_sign;
    logic                   s2_sat;
    fp_convert_pkg::mant_t  s2_mant;
    fp_convert_pkg::int_t   s2_shifted;
    fp_convert_pkg::shift_t s2_lsb_index;

    always_ff @(posedge clock) begin
        s2_sign      <= s1_sign;
        s2_sat       <= overflow;
        s2_mant      <= s1_mant;
        s2_shifted   <= shifted;
        s2_lsb_index <= lsb_index;
    end

    //////////////////////////////////////////////////////////////////////////
    // Stage 3 rounds the magnitude and applies the sign
    //////////////////////////////////////////////////////////////////////////

    logic                 round_up;
    fp_convert_pkg::int_t magnitude;

    fti_rounding_engine #(
        .DATA_WIDTH(`FP_MANT_WIDTH)
    ) rounder (
        .data_in      (s2_mant),
        .lsb_index    (s2_lsb_index),
        .mantissa_lsb (s2_shifted[0]),
        .round_up     (round_up)
    );

    // Largest rounded magnitude is about 2^23, so this add cannot wrap
    assign magnitude = s2_shifted + fp_convert_pkg::int_t'(round_up);

    always_ff @(posedge clock) begin
        if (s2_sat) begin
            out_data <= s2_shifted;
        end else begin
            out_data <= s2_sign ? -magnitude : magnitude;
        end
    end

    // Fixed latency, one result per accepted float
    fixed_latency: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid == $past(in_valid, `FP_PIPE_DEPTH))
        else $error("float to integer strobe broke the fixed pipeline latency");

endmodule

/* design/fp_itf.sv */
`timescale 1ns/1ps
`include "fp_convert_config.svh"

module fp_itf (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  fp_convert_pkg::int_t   in_data,
    output logic                   out_valid,
    output fp_convert_pkg::float_t out_data
);

    localparam int INT_W    = `FP_INT_WIDTH;
    localparam int FRAC_W   = `FP_MANT_WIDTH - 1;
    localparam int DROP_W   = INT_W - `FP_MANT_WIDTH;
    localparam int LZ_WIDTH = $clog2(INT_W) + 1;
    // Biased exponent of a magnitude whose leading one sits in the MSB
    localparam int EXP_TOP  = `FP_EXP_BIAS + INT_W - 1;

    logic s1_valid;
    logic s2_valid;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Stage 1, sign and unsigned magnitude
    //////////////////////////////////////////////////////////////////////////

    logic             s1_sign;
    logic [INT_W-1:0] s1_mag;

    // Negating -2^31 gives 0x80000000, which read as unsigned is the exact magnitude
    always_ff @(posedge clock) begin
        if (in_valid) begin
            s1_sign <= in_data[INT_W-1];
            s1_mag  <= in_data[INT_W-1] ? INT_W'(-in_data) : INT_W'(in_data);
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Stage 2, leading-zero count and normalization
    //////////////////////////////////////////////////////////////////////////

    logic [LZ_WIDTH-1:0] lead_zeros;

    // Scanning upward leaves the count of the highest set bit
    always_comb begin
        lead_zeros = '0;
        for (int i = 0; i < INT_W; i++) begin
            if (s1_mag[i]) begin
                lead_zeros = LZ_WIDTH'(INT_W - 1 - i);
            end
        end
    end

    logic                     s2_sign;
    logic                     s2_zero;
    logic [INT_W-1:0]         s2_norm;
    logic [`FP_EXP_WIDTH-1:0] s2_exp;

    always_ff @(posedge clock) begin
        s2_sign <= s1_sign;
        s2_zero <= (s1_mag == '0);
        s2_norm <= s1_mag << lead_zeros;
        s2_exp  <= `FP_EXP_WIDTH'(EXP_TOP - lead_zeros);
    end

    //////////////////////////////////////////////////////////////////////////
    // Stage 3, round to nearest even and pack
    //////////////////////////////////////////////////////////////////////////

    fp_convert_pkg::mant_t    top_bits;
    logic                     guard;
    logic                     sticky;
    logic                     round_up;
    logic [`FP_MANT_WIDTH:0]  rounded;
    logic [`FP_EXP_WIDTH-1:0] exp_final;

    assign top_bits = s2_norm[INT_W-1 -: `FP_MANT_WIDTH];
    assign guard    = s2_norm[DROP_W-1];
    assign sticky   = |s2_norm[DROP_W-2:0];
    assign round_up = guard & (sticky | top_bits[0]);
    assign rounded  = {1'b0, top_bits} + (`FP_MANT_WIDTH+1)'(round_up);

    // On a carry out the mantissa becomes 2^24, whose low bits are all zero
    // So the fraction field can be taken from the same bits either way
    assign exp_final = s2_exp + `FP_EXP_WIDTH'(rounded[`FP_MANT_WIDTH]);

    always_ff @(posedge clock) begin
        if (s2_zero) begin
            out_data <= '0;
        end else begin
            out_data <= {s2_sign, exp_final, rounded[FRAC_W-1:0]};
        end
    end

    // Largest integer is below 2^32, far from the infinity encoding
    exp_below_inf: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> (out_data[FRAC_W +: `FP_EXP_WIDTH] != '1))
        else $error("integer to float produced an infinity or NaN exponent");

endmodule

/* design/fti_rounding_engine.sv */
`timescale 1ns/1ps

module fti_rounding_engine #(
    parameter int DATA_WIDTH = 24
) (
    input  logic [DATA_WIDTH-1:0]  data_in,
    input  fp_convert_pkg::shift_t lsb_index,
    input  logic                   mantissa_lsb,
    output logic                   round_up
);

    // Guard is the first bit dropped below the integer LSB
    logic guard;
    // Sticky collects every bit below the guard
    logic sticky;

    // Walk the mantissa once and sort each bit by its place relative to the index
    // An index of 0 matches no bit, so guard and sticky both stay low
    always_comb begin
        guard  = 1'b0;
        sticky = 1'b0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (i == lsb_index - 1) begin
                guard = data_in[i];
            end else if (i < lsb_index - 1) begin
                sticky = sticky | data_in[i];
            end
        end
    end

    // Round half to even
    // Above one half rounds up, an exact half rounds up only from an odd result
    assign round_up = guard & (sticky | mantissa_lsb);

    // The index comes from the exponent decode in the converter pipeline
    // Anything past the mantissa would mean that decode lets a wide shift through
    // Before the first float reaches stage 2 the index is still unknown
    lsb_index_in_range: assert property (@(lsb_index)
        !$isunknown(lsb_index) |-> lsb_index <= DATA_WIDTH)
        else $error("rounding index %0d is past the mantissa width", lsb_index);

endmodule

/* fp_convert.f */
+incdir+design
design/fp_convert_pkg.sv
design/fti_rounding_engine.sv
design/fp_fti.sv
design/fp_itf.sv
design/fp_convert_unit.sv
test/fp_convert_checker.sv
test/fp_convert_tb.sv

/* test/fp_convert_checker.sv */
`timescale 1ns/1ps
`include "fp_convert_config.svh"

module fp_convert_checker (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   fti_in_valid,
    input  fp_convert_pkg::float_t fti_in_data,
    input  logic                   fti_out_valid,
    input  fp_convert_pkg::int_t   fti_out_data,
    input  logic                   itf_in_valid,
    input  fp_convert_pkg::int_t   itf_in_data,
    input  logic                   itf_out_valid,
    input  fp_convert_pkg::float_t itf_out_data,
    output logic                   idle,
    output int                     errors
);

    // One entry per accepted input, oldest first, for each path
    fp_convert_pkg::float_t fti_in_q[$];
    fp_convert_pkg::int_t   fti_exp_q[$];
    int                     fti_cyc_q[$];
    fp_convert_pkg::int_t   itf_in_q[$];
    fp_convert_pkg::float_t itf_exp_q[$];
    int                     itf_cyc_q[$];

    int cycle = 0;
    int tests = 0;
    int test_checks = 0;
    int test_errors = 0;
    int total_checks = 0;
    int total_errors = 0;

    assign errors = total_errors;

    ////////////////////////////////////////////////////////////////////////////
    // Reference models
    ////////////////////////////////////////////////////////////////////////////

    // Float to integer with the fraction rounded half to even on the magnitude
    function automatic fp_convert_pkg::int_t fti_model(input fp_convert_pkg::float_t f);
        int     e;
        int     shift;
        longint mant;
        longint mag;
        longint rem;
        longint half;
        e = int'(f[30:23]) - `FP_EXP_BIAS;
        // Infinities, NaNs and anything from 2^31 up saturate by the sign bit
        if (f[30:23] == 8'hff || e >= 31) begin
            return f[31] ? 32'h80000000 : 32'h7fffffff;
        end
        // Subnormals, zeros and magnitudes below one half all land on 0
        if (f[30:23] == 8'h00 || e < -1) begin
            return 32'd0;
        end
        mant = {1'b1, f[22:0]};
        if (e >= 23) begin
            mag = mant << (e - 23);
        end else begin
            shift = 23 - e;
            mag   = mant >> shift;
            rem   = mant - (mag << shift);
            half  = longint'(1) << (shift - 1);
            if (rem > half || (rem == half && mag[0])) begin
                mag = mag + 1;
            end
        end
        return f[31] ? -mag : mag;
    endfunction

    // Integer to the nearest float, ties to even, built from the leading one
    function automatic fp_convert_pkg::float_t itf_model(input fp_convert_pkg::int_t v);
        longint mag;
        longint m;
        longint rem;
        longint half;
        int     p;
        int     shift;
        int     e;
        if (v == 0) begin
            return 32'd0;
        end
        mag = (v < 0) ? -longint'(v) : longint'(v);
        p = 0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i]) begin
                p = i;
            end
        end
        e = `FP_EXP_BIAS + p;
        if (p <= 23) begin
            m = mag << (23 - p);
        end else begin
            shift = p - 23;
            m     = mag >> shift;
            rem   = mag - (m << shift);
            half  = longint'(1) << (shift - 1);
            if (rem > half || (rem == half && m[0])) begin
                m = m + 1;
            end
            // A full carry moves the leading one up by a place
            if (m == (longint'(1) << 24)) begin
                m = m >> 1;
                e = e + 1;
            end
        end
        return {v[31], e[7:0], m[22:0]};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Comparing and counting
    ////////////////////////////////////////////////////////////////////////////

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic check_fti_output();
        fp_convert_pkg::float_t din;
        fp_convert_pkg::int_t   expv;
        int                     c;
        if (fti_in_q.size() == 0) begin
            $display("%0t: float to integer output strobe with no input waiting", $time);
            note_error();
        end else begin
            din  = fti_in_q.pop_front();
            expv = fti_exp_q.pop_front();
            c    = fti_cyc_q.pop_front();
            test_checks++;
            total_checks++;
            if (fti_out_data !== expv) begin
                $display("CHECK FAILED at %0t: float to integer of %h gave %0d, expected %0d",
                         $time, din, fti_out_data, expv);
                note_error();
            end
            if (cycle - c != `FP_PIPE_DEPTH) begin
                $display("%0t: float to integer result came %0d clocks after its input",
                         $time, cycle - c);
                note_error();
            end
        end
    endtask

    task automatic check_itf_output();
        fp_convert_pkg::int_t   din;
        fp_convert_pkg::float_t expv;
        int                     c;
        if (itf_in_q.size() == 0) begin
            $display("%0t: integer to float output strobe with no input waiting", $time);
            note_error();
        end else begin
            din  = itf_in_q.pop_front();
            expv = itf_exp_q.pop_front();
            c    = itf_cyc_q.pop_front();
            test_checks++;
            total_checks++;
            if (itf_out_data !== expv) begin
                $display("CHECK FAILED at %0t: integer to float of %0d gave %h, expected %h",
                         $time, din, itf_out_data, expv);
                note_error();
            end
            if (cycle - c != `FP_PIPE_DEPTH) begin
                $display("%0t: integer to float result came %0d clocks after its input",
                         $time, cycle - c);
                note_error();
            end
        end
    endtask

    // Inputs and outputs are read at the rising edge, before that edge updates them
    always @(posedge clock) begin
        cycle = cycle + 1;
        if (!rst_n) begin
            // The very first edge is the one that clears the valid registers
            if (cycle > 1 && (fti_out_valid !== 1'b0 || itf_out_valid !== 1'b0)) begin
                $display("%0t: an output valid was not low during reset", $time);
                note_error();
            end
        end else begin
            if (fti_in_valid) begin
                fti_in_q.push_back(fti_in_data);
                fti_exp_q.push_back(fti_model(fti_in_data));
                fti_cyc_q.push_back(cycle);
            end
            if (itf_in_valid) begin
                itf_in_q.push_back(itf_in_data);
                itf_exp_q.push_back(itf_model(itf_in_data));
                itf_cyc_q.push_back(cycle);
            end
            if (fti_out_valid) begin
                check_fti_output();
            end
            if (itf_out_valid) begin
                check_itf_output();
            end
        end
        idle <= (fti_in_q.size() == 0) && (itf_in_q.size() == 0);
    end

    task automatic finish_test(input string name);
        tests++;
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic report_totals();
        $display("%0d tests, %0d checks, %0d errors", tests, total_checks, total_errors);
    endtask

endmodule

/* test/fp_convert_tb.sv */
`timescale 1ns/1ps

module fp_convert_tb;

    logic                   clock;
    logic                   rst_n;
    logic                   fti_in_valid;
    fp_convert_pkg::float_t fti_in_data;
    logic                   fti_out_valid;
    fp_convert_pkg::int_t   fti_out_data;
    logic                   itf_in_valid;
    fp_convert_pkg::int_t   itf_in_data;
    logic                   itf_out_valid;
    fp_convert_pkg::float_t itf_out_data;
    logic                   idle;
    int                     errors;
    integer                 seed;
    logic                   timed_out;

    fp_convert_unit UUT (
        .clock         (clock),
        .rst_n         (rst_n),
        .fti_in_valid  (fti_in_valid),
        .fti_in_data   (fti_in_data),
        .fti_out_valid (fti_out_valid),
        .fti_out_data  (fti_out_data),
        .itf_in_valid  (itf_in_valid),
        .itf_in_data   (itf_in_data),
        .itf_out_valid (itf_out_valid),
        .itf_out_data  (itf_out_data)
    );

    fp_convert_checker scoreboard (
        .clock         (clock),
        .rst_n         (rst_n),
        .fti_in_valid  (fti_in_valid),
        .fti_in_data   (fti_in_data),
        .fti_out_valid (fti_out_valid),
        .fti_out_data  (fti_out_data),
        .itf_in_valid  (itf_in_valid),
        .itf_in_data   (itf_in_data),
        .itf_out_valid (itf_out_valid),
        .itf_out_data  (itf_out_data),
        .idle          (idle),
        .errors        (errors)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Driving helpers
    ////////////////////////////////////////////////////////////////////////////

    // All four inputs change together just after a rising edge
    task automatic drive_inputs(input logic fv, input fp_convert_pkg::float_t fd,
                                input logic iv, input fp_convert_pkg::int_t id);
        @(posedge clock);
        fti_in_valid <= fv;
        fti_in_data  <= fd;
        itf_in_valid <= iv;
        itf_in_data  <= id;
    endtask

    task automatic send_float(input fp_convert_pkg::float_t f);
        drive_inputs(1'b1, f, 1'b0, 32'd0);
    endtask

    task automatic send_int(input fp_convert_pkg::int_t v);
        drive_inputs(1'b0, 32'd0, 1'b1, v);
    endtask

    // Idle is read one edge late, so the last item is already queued by then
    task automatic wait_for_results(input string name);
        int waited;
        drive_inputs(1'b0, 32'd0, 1'b0, 32'd0);
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
        end while (!idle && waited < 200);
        if (!idle) begin
            $display("timeout: results of test %s did not all arrive", name);
            timed_out = 1'b1;
        end
        scoreboard.finish_test(name);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    // Exponents -2 to 30 with any fraction and sign
    task automatic normal_floats();
        fp_convert_pkg::float_t f;
        repeat (300) begin
            f = $random(seed);
            f[30:23] = 8'd125 + 8'($unsigned($random(seed)) % 33);
            send_float(f);
        end
        wait_for_results("normal floats");
    endtask

    task automatic saturation();
        fp_convert_pkg::float_t f;
        fp_convert_pkg::float_t specials [8] = '{32'h4F000000, 32'hCF000000, 32'h4EFFFFFF,
            32'h7F800000, 32'hFF800000, 32'h7FC00000, 32'hFFFFFFFF, 32'h7F800001};
        repeat (60) begin
            f = $random(seed);
            f[30:23] = 8'd158 + 8'($unsigned($random(seed)) % 97);
            send_float(f);
        end
        foreach (specials[i]) begin
            send_float(specials[i]);
        end
        wait_for_results("saturation and specials");
    endtask

    // Exact halves, values near one half, subnormals and both zeros
    task automatic ties_and_small();
        fp_convert_pkg::float_t f;
        fp_convert_pkg::float_t cases [15] = '{32'h3F000000, 32'hBF000000, 32'h3FC00000,
            32'h40200000, 32'hC0200000, 32'h40600000, 32'h3EFFFFFF, 32'h3E800000,
            32'h3F400000, 32'h00000001, 32'h807FFFFF, 32'h00000000, 32'h80000000,
            32'h4B7FFFFF, 32'h4AFFFFFF};
        foreach (cases[i]) begin
            send_float(cases[i]);
        end
        repeat (40) begin
            f = $random(seed);
            f[30:23] = f[0] ? 8'd0 : 8'd124 + 8'($unsigned($random(seed)) % 4);
            send_float(f);
        end
        wait_for_results("ties and small values");
    endtask

    task automatic random_ints();
        repeat (300) begin
            send_int($random(seed));
        end
        wait_for_results("random integers");
    endtask

    // Several of these sit exactly halfway between two floats
    task automatic int_edges();
        fp_convert_pkg::int_t cases [12] = '{32'd0, 32'd1, 32'hFFFFFFFF, 32'h7FFFFFFF,
            32'h80000000, 32'h01000001, 32'h01000003, 32'hFEFFFFFF, 32'h02000002,
            32'h02000006, 32'h00FFFFFF, 32'h7FFFFFC0};
        foreach (cases[i]) begin
            send_int(cases[i]);
        end
        wait_for_results("integer edges");
    endtask

    // Both paths at full rate with about one clock in four left empty
    task automatic throughput();
        logic                   fv;
        logic                   iv;
        fp_convert_pkg::float_t fd;
        fp_convert_pkg::int_t   id;
        repeat (200) begin
            fv = ($random(seed) & 3) != 0;
            iv = ($random(seed) & 3) != 0;
            fd = $random(seed);
            id = $random(seed);
            drive_inputs(fv, fd, iv, id);
        end
        wait_for_results("throughput");
    endtask

    initial begin
        seed         = 75530;
        timed_out    = 1'b0;
        rst_n        = 1'b0;
        fti_in_valid = 1'b0;
        fti_in_data  = '0;
        itf_in_valid = 1'b0;
        itf_in_data  = '0;
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        normal_floats();
        if (!timed_out) begin
            saturation();
        end
        if (!timed_out) begin
            ties_and_small();
        end
        if (!timed_out) begin
            random_ints();
        end
        if (!timed_out) begin
            int_edges();
        end
        if (!timed_out) begin
            throughput();
        end
        scoreboard.report_totals();
        if (timed_out || errors != 0) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule
